// ==== beamscaler_top.f ====
+incdir+tb
verilog/scaler_cfg_pkg.sv
verilog/scaler_ctrl_pkg.sv
verilog/scaler_wr_if.sv
verilog/quad_scaler.sv
verilog/scaler_update_ctrl.sv
verilog/scaler_bank_ram.sv
verilog/beamscaler_top.sv
tb/beamscaler_tb.sv

// ==== tb/beamscaler_tb_ref.svh ====
`ifndef BEAMSCALER_TB_REF_SVH
`define BEAMSCALER_TB_REF_SVH

// full scale of one 12-bit scaler
localparam int COUNT_MAX = 4095;

// counts of the period in progress, real beams then subthreshold beams
int tally [2*NBEAMS];
// counts of the last completed period, what the bus should show
int period [2*NBEAMS];

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one cycle of trigger bits, saturating like the hardware
function automatic void tally_cycle(input logic [2*NBEAMS-1:0] bits);
    for (int i = 0; i < 2*NBEAMS; i++) begin
        if (bits[i] && tally[i] < COUNT_MAX) begin
            tally[i] = tally[i] + 1;
        end
    end
endfunction

// an update closes the period, next one starts from zero
function automatic void close_period();
    for (int i = 0; i < 2*NBEAMS; i++) begin
        period[i] = tally[i];
        tally[i]  = 0;
    end
endfunction

// bus value for a scaler address
// real beam b at b, subthreshold beam b at 64+b, unused lanes read 0
function automatic logic [31:0] expected_count(input logic [6:0] adr);
    int beam;
    beam = adr[5:0];
    if (beam >= NBEAMS) begin
        return 32'd0;
    end
    return adr[6] ? period[NBEAMS + beam] : period[beam];
endfunction

`endif

// ==== tb/beamscaler_tb.sv ====
`timescale 1ns/1ps

module beamscaler_tb;

    localparam int NBEAMS = 6;
    // real and subthreshold groups, quads rounded up
    localparam int NUM_QUADS = 2 * ((NBEAMS + 3) / 4);
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int DONE_WATCHDOG = 100;
    // real beam 2 and subthreshold beam 5 held high
    localparam logic [2*NBEAMS-1:0] SAT_MASK = (1 << 2) | (1 << (NBEAMS + 5));

    logic                wb_clk_i = 1'b0;
    logic                wb_rst_i;
    logic [2*NBEAMS-1:0] count_i;
    logic                timer_i;
    logic                done_o;
    logic                write_bank_o;
    logic                scal_rd_i;
    logic [6:0]          scal_adr_i;
    logic [31:0]         scal_dat_o;

    int          cycle_cnt = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'h3c9f_2b32;
    logic        exp_bank = 1'b0;
    logic [31:0] last_dat = '0;
    string       test_name = "reset";
    // outstanding reads: cycle the data is due, address, expected value
    int          due_q [$];
    int          adr_q [$];
    logic [31:0] exp_q [$];

    `include "beamscaler_tb_ref.svh"

    beamscaler_top #(
        .NBEAMS (NBEAMS)
    ) UUT (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .count_i      (count_i),
        .timer_i      (timer_i),
        .done_o       (done_o),
        .write_bank_o (write_bank_o),
        .scal_rd_i    (scal_rd_i),
        .scal_adr_i   (scal_adr_i),
        .scal_dat_o   (scal_dat_o)
    );

    // 4 ns clock
    always #2 wb_clk_i = ~wb_clk_i;

    always @(posedge wb_clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("ERROR: timeout after %0d cycles, %0d errors so far", TIMEOUT_CYCLES, errors);
        $display("Test failed");
        $finish;
    end

    task automatic report_mismatch(input string what, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("FAILED %s: %s expected %0d actual %0d", test_name, what, expv, actv);
        errors++;
    endtask

    // sample one ns after the edge, data lands two edges after the request
    always @(posedge wb_clk_i) begin
        #1;
        if (!wb_rst_i) begin
            if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
                checks++;
                if (scal_dat_o !== exp_q[0]) begin
                    report_mismatch($sformatf("scal_dat_o at address %0d", adr_q[0]),
                                    exp_q[0], scal_dat_o);
                end
                last_dat = scal_dat_o;
                void'(due_q.pop_front());
                void'(adr_q.pop_front());
                void'(exp_q.pop_front());
            end else if (scal_dat_o !== last_dat) begin
                // no read due, output must hold
                report_mismatch("scal_dat_o hold between reads", last_dat, scal_dat_o);
            end
        end
    end

    task automatic issue_read(input logic [6:0] adr);
        @(posedge wb_clk_i);
        #1;
        scal_rd_i  = 1'b1;
        scal_adr_i = adr;
        due_q.push_back(cycle_cnt + 2);
        adr_q.push_back(adr);
        exp_q.push_back(expected_count(adr));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge wb_clk_i);
            #1;
            scal_rd_i = 1'b0;
        end
    endtask

    // both populated quads of each group, unused lanes too
    task automatic read_all();
        for (int a = 0; a < 8; a++) begin
            issue_read(7'(a));
            idle_cycles(2);
        end
        for (int a = 0; a < 8; a++) begin
            issue_read(7'(64 + a));
            idle_cycles(2);
        end
    endtask

    // one LFSR step per trigger bit, forced bits stay high
    task automatic drive_counts(input int cycles, input logic [2*NBEAMS-1:0] force_mask);
        logic [2*NBEAMS-1:0] bits;
        repeat (cycles) begin
            @(posedge wb_clk_i);
            #1;
            for (int i = 0; i < 2*NBEAMS; i++) begin
                lfsr    = lfsr_step(lfsr);
                bits[i] = lfsr[0];
            end
            bits    = bits | force_mask;
            count_i = bits;
            tally_cycle(bits);
        end
    endtask

    task automatic pulse_timer();
        @(posedge wb_clk_i);
        #1;
        timer_i = 1'b1;
        @(posedge wb_clk_i);
        #1;
        timer_i = 1'b0;
    endtask

    // waited counts edges from one cycle after the timer cycle
    task automatic wait_done(output int waited);
        waited = 0;
        do begin
            @(posedge wb_clk_i);
            #1;
            waited++;
        end while (done_o !== 1'b1 && waited < DONE_WATCHDOG);
        checks++;
        if (done_o !== 1'b1) begin
            $display("ERROR %s: update never finished, no done_o within %0d cycles",
                     test_name, DONE_WATCHDOG);
            errors++;
        end else begin
            exp_bank = ~exp_bank;
            close_period();
            if (write_bank_o !== exp_bank) begin
                report_mismatch("write_bank_o after done_o", exp_bank, write_bank_o);
            end
        end
    endtask

    task automatic run_update();
        int waited;
        // quiet triggers so the capture cycle adds nothing
        @(posedge wb_clk_i);
        #1;
        count_i = '0;
        @(posedge wb_clk_i);
        pulse_timer();
        wait_done(waited);
        // done rises NUM_QUADS+3 cycles after the timer cycle
        checks += 2;
        if (waited + 1 != NUM_QUADS + 3) begin
            report_mismatch("done_o latency in cycles", NUM_QUADS + 3, waited + 1);
        end
        @(posedge wb_clk_i);
        #1;
        if (done_o !== 1'b0) begin
            report_mismatch("done_o one cycle after the pulse", 0, done_o);
        end
    endtask

    initial begin
        int waited;
        wb_rst_i   = 1'b1;
        count_i    = '0;
        timer_i    = 1'b0;
        scal_rd_i  = 1'b0;
        scal_adr_i = '0;
        repeat (10) @(posedge wb_clk_i);
        #1;
        wb_rst_i = 1'b0;

        test_name = "reset_and_empty_update";
        checks += 2;
        if (done_o !== 1'b0) begin
            report_mismatch("done_o after reset", 0, done_o);
        end
        if (write_bank_o !== 1'b0) begin
            report_mismatch("write_bank_o after reset", 0, write_bank_o);
        end
        run_update();
        read_all();

        test_name = "random_counts";
        drive_counts(800, '0);
        run_update();
        read_all();

        test_name = "saturation_and_map";
        drive_counts(5000, SAT_MASK);
        run_update();
        read_all();

        test_name = "read_hold_and_back_to_back";
        issue_read(7'd69);
        idle_cycles(5);
        for (int a = 0; a < NBEAMS; a++) begin
            issue_read(7'(a));
        end
        for (int a = 0; a < NBEAMS; a++) begin
            issue_read(7'(64 + a));
        end
        idle_cycles(3);

        test_name = "timer_during_update";
        pulse_timer();
        // second pulse lands while the chain is shifting
        repeat (2) @(posedge wb_clk_i);
        pulse_timer();
        wait_done(waited);
        wait_done(waited);
        read_all();

        idle_cycles(3);
        checks++;
        if (due_q.size() != 0) begin
            $display("ERROR %s: %0d reads never returned data", test_name, due_q.size());
            errors++;
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/beamscaler_top.sv ====
`timescale 1ns/1ps

module beamscaler_top
    import scaler_cfg_pkg::*;
    import scaler_ctrl_pkg::*;
#(
    parameter int NBEAMS = 6
) (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    // low half real triggers, high half subthreshold
    input  logic [2*NBEAMS-1:0]    count_i,
    input  logic                   timer_i,
    output logic                   done_o,
    output logic                   write_bank_o,
    input  logic                   scal_rd_i,
    input  logic [SCAL_ADDR_W-1:0] scal_adr_i,
    output logic [SCAL_DATA_W-1:0] scal_dat_o
);

    // quads per group, rounded up
    localparam int GROUP_QUADS = (NBEAMS + QUAD_LANES - 1) / QUAD_LANES;
    // real group then subthreshold group
    localparam int NUM_QUADS   = 2 * GROUP_QUADS;

    // chain[q] feeds position q, chain[NUM_QUADS] is the tail
    quad_word_t chain [NUM_QUADS+1];
    chain_cmd_e cmd;

    scaler_wr_if wr_bus ();

    // head of the chain shifts in zeros
    assign chain[0] = '0;

    for (genvar q = 0; q < NUM_QUADS; q++) begin : g_quad
        // group and quad number inside the group
        localparam int SUB  = (q >= GROUP_QUADS) ? 1 : 0;
        localparam int GQ   = q - SUB * GROUP_QUADS;
        localparam int BASE = SUB * NBEAMS + GQ * QUAD_LANES;

        logic [QUAD_LANES-1:0] quad_count;

        for (genvar l = 0; l < QUAD_LANES; l++) begin : g_lane
            if (GQ * QUAD_LANES + l < NBEAMS) begin : g_used
                assign quad_count[l] = count_i[BASE + l];
            end else begin : g_unused
                // past the last beam of this group
                assign quad_count[l] = 1'b0;
            end
        end

        quad_scaler u_quad (
            .wb_clk_i (wb_clk_i),
            .wb_rst_i (wb_rst_i),
            .count_i  (quad_count),
            .cmd_i    (cmd),
            .chain_i  (chain[q]),
            .chain_o  (chain[q+1])
        );
    end

    scaler_update_ctrl #(
        .NUM_QUADS (NUM_QUADS)
    ) u_ctrl (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .timer_i      (timer_i),
        .chain_tail_i (chain[NUM_QUADS]),
        .cmd_o        (cmd),
        .wr           (wr_bus.ctrl),
        .write_bank_o (write_bank_o),
        .done_o       (done_o)
    );

    // memory reads the complement of the write bank
    scaler_bank_ram u_ram (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .wr          (wr_bus.ram),
        .read_bank_i (write_bank_o),
        .scal_rd_i   (scal_rd_i),
        .scal_adr_i  (scal_adr_i),
        .scal_dat_o  (scal_dat_o)
    );

endmodule

// ==== verilog/scaler_bank_ram.sv ====
`timescale 1ns/1ps

module scaler_bank_ram
    import scaler_cfg_pkg::*;
(
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    scaler_wr_if.ram               wr,
    input  logic                   read_bank_i,
    input  logic                   scal_rd_i,
    input  logic [SCAL_ADDR_W-1:0] scal_adr_i,
    output logic [SCAL_DATA_W-1:0] scal_dat_o
);

    // low address bits pick the lane inside a quad
    localparam int LANE_W = SCAL_ADDR_W - QUAD_ADDR_W;
    // two banks of quads
    localparam int DEPTH  = 2 ** (QUAD_ADDR_W + 1);

    logic [QUAD_W-1:0]    mem [DEPTH];
    logic [QUAD_ADDR_W:0] rd_addr;
    quad_word_t           rd_word_q;
    logic [LANE_W-1:0]    rd_lane_q;
    logic                 rd_pend_q;

    // bank bit on top
    // read_bank_i is the bank being written, so read the other one
    assign rd_addr = {~read_bank_i, scal_adr_i[SCAL_ADDR_W-1:LANE_W]};

    // quad write port
    always_ff @(posedge wb_clk_i) begin
        if (wr.wr_en) begin
            mem[{wr.wr_bank, wr.wr_quad}] <= wr.wr_data;
        end
    end

    // read stage one, whole quad word and lane number
    always_ff @(posedge wb_clk_i) begin
        if (scal_rd_i) begin
            rd_word_q <= mem[rd_addr];
            rd_lane_q <= scal_adr_i[LANE_W-1:0];
        end
    end

    // read stage two, lane select and zero extend
    // output holds until the next read comes through
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            rd_pend_q  <= 1'b0;
            scal_dat_o <= '0;
        end else begin
            rd_pend_q <= scal_rd_i;
            if (rd_pend_q) begin
                scal_dat_o <= {{(SCAL_DATA_W-COUNT_W){1'b0}}, rd_word_q[rd_lane_q]};
            end
        end
    end

endmodule

// ==== verilog/scaler_update_ctrl.sv ====
`timescale 1ns/1ps

module scaler_update_ctrl
    import scaler_cfg_pkg::*;
    import scaler_ctrl_pkg::*;
#(
    parameter int NUM_QUADS = 4
) (
    input  logic       wb_clk_i,
    input  logic       wb_rst_i,
    input  logic       timer_i,
    input  quad_word_t chain_tail_i,
    output chain_cmd_e cmd_o,
    scaler_wr_if.ctrl  wr,
    output logic       write_bank_o,
    output logic       done_o
);

    // chain holds the real quads first, subthreshold quads after
    localparam int REAL_QUADS = NUM_QUADS / 2;
    localparam logic [QUAD_ADDR_W-1:0] REAL_QUADS_A = QUAD_ADDR_W'(REAL_QUADS);
    localparam logic [QUAD_ADDR_W-1:0] LAST_IDX = QUAD_ADDR_W'(NUM_QUADS - 1);
    // subthreshold position p lands at SUB_QUAD_BASE + (p - REAL_QUADS)
    localparam logic [QUAD_ADDR_W-1:0] SUB_OFFSET = QUAD_ADDR_W'(SUB_QUAD_BASE - REAL_QUADS);

    update_state_e          state_q;
    update_state_e          state_d;
    logic                   timer_pend_q;
    logic [QUAD_ADDR_W-1:0] idx_q;
    logic                   bank_q;
    logic                   done_q;
    logic                   last_write;

    // tail word of position 0 is being written this cycle
    assign last_write = (state_q == ST_WRITE) && (idx_q == '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (timer_pend_q) begin
                    state_d = ST_CAPTURE;
                end
            end
            ST_CAPTURE: begin
                state_d = ST_WRITE;
            end
            ST_WRITE: begin
                if (idx_q == '0) begin
                    state_d = ST_FINISH;
                end
            end
            ST_FINISH: begin
                // a pulse held during the update starts the next one at once
                state_d = timer_pend_q ? ST_CAPTURE : ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q      <= ST_IDLE;
            timer_pend_q <= 1'b0;
            idx_q        <= '0;
            bank_q       <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            state_q <= state_d;
            // a new pulse wins over the clear in the capture cycle
            if (timer_i) begin
                timer_pend_q <= 1'b1;
            end else if (state_q == ST_CAPTURE) begin
                timer_pend_q <= 1'b0;
            end
            // the tail holds the highest position first
            if (state_q == ST_CAPTURE) begin
                idx_q <= LAST_IDX;
            end else if (state_q == ST_WRITE) begin
                idx_q <= idx_q - 1'b1;
            end
            // flip and done both show up in ST_FINISH
            done_q <= last_write;
            if (last_write) begin
                bank_q <= ~bank_q;
            end
        end
    end

    always_comb begin
        case (state_q)
            ST_CAPTURE: cmd_o = CMD_CAPTURE;
            ST_WRITE:   cmd_o = CMD_SHIFT;
            default:    cmd_o = CMD_HOLD;
        endcase
    end

    // write the tail on the same edge that shifts the chain
    assign wr.wr_en   = (state_q == ST_WRITE);
    // bus reads the other bank meanwhile
    // this one becomes the read bank when the bit flips
    assign wr.wr_bank = bank_q;
    assign wr.wr_quad = (idx_q < REAL_QUADS_A) ? idx_q : idx_q + SUB_OFFSET;
    assign wr.wr_data = chain_tail_i;

    assign write_bank_o = bank_q;
    assign done_o       = done_q;

endmodule

// ==== verilog/quad_scaler.sv ====
`timescale 1ns/1ps

module quad_scaler
    import scaler_cfg_pkg::*;
    import scaler_ctrl_pkg::*;
(
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,
    input  logic [QUAD_LANES-1:0] count_i,
    input  chain_cmd_e            cmd_i,
    input  quad_word_t            chain_i,
    output quad_word_t            chain_o
);

    // running counts of the current period
    quad_word_t cnt_q;
    // counts of the last completed period
    // doubles as this block's stage of the shift chain
    quad_word_t shadow_q;

    // four saturating counters
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            cnt_q <= '0;
        end else begin
            for (int l = 0; l < QUAD_LANES; l++) begin
                if (cmd_i == CMD_CAPTURE) begin
                    // new period starts with this cycle's input
                    cnt_q[l] <= {{(COUNT_W-1){1'b0}}, count_i[l]};
                end else if (count_i[l] && (cnt_q[l] != {COUNT_W{1'b1}})) begin
                    // stick at full scale
                    cnt_q[l] <= cnt_q[l] + 1'b1;
                end
            end
        end
    end

    // shadow register and chain stage
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            shadow_q <= '0;
        end else begin
            case (cmd_i)
                CMD_CAPTURE: begin
                    // all quads snapshot on the same edge
                    shadow_q <= cnt_q;
                end
                CMD_SHIFT: begin
                    // move one stage toward the tail
                    shadow_q <= chain_i;
                end
                default: begin
                    shadow_q <= shadow_q;
                end
            endcase
        end
    end

    // the shadow feeds the next stage downstream
    assign chain_o = shadow_q;

endmodule

// ==== verilog/scaler_wr_if.sv ====
`timescale 1ns/1ps

interface scaler_wr_if
    import scaler_cfg_pkg::*;
    ();

    // write strobe, one quad lands at each edge it is high
    logic                   wr_en;
    // bank the current update is filling
    logic                   wr_bank;
    // quad address after the real/subthreshold remap
    logic [QUAD_ADDR_W-1:0] wr_quad;
    quad_word_t             wr_data;

    // update controller side
    modport ctrl (
        output wr_en,
        output wr_bank,
        output wr_quad,
        output wr_data
    );

    // scaler memory side
    modport ram (
        input wr_en,
        input wr_bank,
        input wr_quad,
        input wr_data
    );

endinterface

// ==== verilog/scaler_ctrl_pkg.sv ====
package scaler_ctrl_pkg;

    // command broadcast to every quad scaler in the chain
    typedef enum logic [1:0] {
        CMD_HOLD    = 2'd0,
        CMD_CAPTURE = 2'd1,
        CMD_SHIFT   = 2'd2
    } chain_cmd_e;

    // update controller states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_CAPTURE = 2'd1,
        ST_WRITE   = 2'd2,
        ST_FINISH  = 2'd3
    } update_state_e;

endpackage

// ==== verilog/scaler_cfg_pkg.sv ====
package scaler_cfg_pkg;

    // width of one scaler count, saturates at all ones
    localparam int COUNT_W = 12;

    // scalers packed into one quad word
    localparam int QUAD_LANES = 4;

    // flat width of a quad word, used for memory storage
    localparam int QUAD_W = QUAD_LANES * COUNT_W;

    // quad word, lane 0 sits in the low bits
    typedef logic [QUAD_LANES-1:0][COUNT_W-1:0] quad_word_t;

    // quad address inside one bank
    // 32 quads, so 128 scalers per bank
    localparam int QUAD_ADDR_W = 5;

    // first subthreshold quad, scaler address 64
    // fixed so the map does not move with the beam count
    localparam int SUB_QUAD_BASE = 16;

    // bus side scaler address and read data
    localparam int SCAL_ADDR_W = 7;
    localparam int SCAL_DATA_W = 32;

endpackage
